// File: build.f
+incdir+rtl
rtl/i2s_pkg.sv
rtl/i2s_edge_if.sv
rtl/i2s_pin_decoder.sv
rtl/i2s_adc_deserializer.sv
rtl/i2s_dac_serializer.sv
rtl/frame_decimator.sv
rtl/i2s_codec_bridge.sv
verification/i2s_codec_bridge_sva.sv
verification/i2s_codec_bridge_tb.sv

// File: verification/i2s_codec_bridge_tb.sv
`timescale 1ns/1ps

module i2s_codec_bridge_tb;

  localparam int BCLK_HALF = 8;
  localparam int MAIN_FRAMES = 40;
  localparam int GROUP = 4;
  localparam int WAIT_LIMIT = 4000;
  localparam logic [31:0] SEED = 32'h9a14_5971;

  logic        aclk;
  logic        aresetn;
  logic        bclk;
  logic        lrclk;
  logic        adc_sdata;
  logic        dac_sdata;
  logic [31:0] s_tdata;
  logic        s_tvalid;
  logic        s_tready;
  logic [31:0] m_tdata;
  logic        m_tvalid;
  logic        m_tready;
  logic        overrun;

  logic [31:0] codec_lfsr;
  logic [31:0] ready_lfsr;
  logic [31:0] ready_pick;
  logic        hold_ready;
  logic [15:0] prev_right;
  logic [15:0] dac_left;
  logic [15:0] dac_right;
  int          frames_sent;
  int          tready_count;
  int          adc_left[$];
  int          adc_right[$];
  logic [31:0] capture_q[$];
  logic [31:0] play_q[$];

  i2s_codec_bridge dut (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .bclk      (bclk),
    .lrclk     (lrclk),
    .adc_sdata (adc_sdata),
    .dac_sdata (dac_sdata),
    .s_tdata   (s_tdata),
    .s_tvalid  (s_tvalid),
    .s_tready  (s_tready),
    .m_tdata   (m_tdata),
    .m_tvalid  (m_tvalid),
    .m_tready  (m_tready),
    .overrun   (overrun)
  );

  always #2 aclk = ~aclk;

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("Error: time %0t, %s is %h, expected %h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  // --------------------------------------------------
  // random source and reference model
  // --------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  task automatic take_bits(inout logic [31:0] state, input int count,
                           output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < count; i++)
    begin
      state = lfsr_step(state);
      value = {value[30:0], state[0]};
    end
  endtask

  // integer division rounds toward zero, so negative sums are corrected to floor
  function automatic logic [15:0] floor_avg(input int sum);
    int quotient;
    if (sum >= 0)
      quotient = sum / GROUP;
    else
      quotient = -((-sum + GROUP - 1) / GROUP);
    return quotient[15:0];
  endfunction

  task automatic record_adc_frame(input logic [15:0] left, input logic [15:0] right);
    int sum_left;
    int sum_right;
    adc_left.push_back(int'($signed(left)));
    adc_right.push_back(int'($signed(right)));
    if (adc_left.size() == GROUP)
    begin
      sum_left = 0;
      sum_right = 0;
      while (adc_left.size() != 0)
      begin
        sum_left += adc_left.pop_front();
        sum_right += adc_right.pop_front();
      end
      capture_q.push_back({floor_avg(sum_left), floor_avg(sum_right)});
    end
  endtask

  // --------------------------------------------------
  // codec clock model
  // --------------------------------------------------
  task automatic bit_slot(input logic lr, input logic data, output logic dac_bit);
    bclk = 1'b0;
    lrclk = lr;
    adc_sdata = data;
    repeat (BCLK_HALF) @(negedge aclk);
    dac_bit = dac_sdata;
    bclk = 1'b1;
    repeat (BCLK_HALF) @(negedge aclk);
  endtask

  // half a frame with lrclk high so that frame 0 opens on a real lrclk fall
  task automatic send_preamble();
    logic dac_bit;
    int   k;
    for (k = 0; k < 16; k++)
    begin
      bit_slot(1'b1, 1'b0, dac_bit);
    end
  endtask

  task automatic send_frames(input int count);
    logic [31:0] pick;
    logic [15:0] left;
    logic [15:0] right;
    logic        data;
    logic        dac_bit;
    int          n;
    int          k;
    for (n = 0; n < count; n++)
    begin
      take_bits(codec_lfsr, 16, pick);
      left = pick[15:0];
      take_bits(codec_lfsr, 16, pick);
      right = pick[15:0];
      record_adc_frame(left, right);
      for (k = 0; k < 32; k++)
      begin
        // one-bit delay, slot 0 still carries the previous right LSB
        if (k == 0)
          data = prev_right[0];
        else if (k <= 16)
          data = left[16-k];
        else
          data = right[32-k];
        if (k == 8)
        begin
          take_bits(codec_lfsr, 1, pick);
          s_tvalid = pick[0];
          take_bits(codec_lfsr, 32, pick);
          s_tdata = pick;
        end
        bit_slot(k >= 16, data, dac_bit);
        if (k == 0)
        begin
          dac_right = {dac_right[14:0], dac_bit};
          if (frames_sent > 0)
          begin
            if (play_q.size() == 0)
            begin
              $display("a played frame has no matching playback request");
              abort_run();
            end
            check_value("dac_sdata word", {dac_left, dac_right}, play_q.pop_front());
          end
        end
        else if (k <= 16)
          dac_left = {dac_left[14:0], dac_bit};
        else
          dac_right = {dac_right[14:0], dac_bit};
      end
      prev_right = right;
      frames_sent++;
    end
  endtask

  task automatic wait_capture_drain();
    int cycles;
    cycles = 0;
    while (capture_q.size() != 0)
    begin
      if (cycles == WAIT_LIMIT)
      begin
        $display("timeout waiting for the capture stream to deliver its averages");
        abort_run();
      end
      @(negedge aclk);
      cycles++;
    end
  endtask

  task automatic wait_tvalid_low();
    int cycles;
    cycles = 0;
    while (m_tvalid !== 1'b0)
    begin
      if (cycles == WAIT_LIMIT)
      begin
        $display("timeout waiting for m_tvalid to fall after the held word was taken");
        abort_run();
      end
      @(negedge aclk);
      cycles++;
    end
  endtask

  // --------------------------------------------------
  // stream monitors
  // --------------------------------------------------
  always @(negedge aclk)
  begin
    take_bits(ready_lfsr, 2, ready_pick);
    m_tready = !hold_ready && (ready_pick[1:0] != 2'b00);
    if (aresetn && m_tvalid && m_tready)
    begin
      if (capture_q.size() == 0)
      begin
        $display("a capture word was delivered while no average was expected");
        abort_run();
      end
      check_value("m_tdata", m_tdata, capture_q.pop_front());
    end
  end

  always @(negedge aclk)
  begin
    if (s_tready)
    begin
      tready_count++;
      play_q.push_back(s_tvalid ? s_tdata : 32'h0);
    end
  end

  always @(negedge aclk)
  begin
    if (dut.u_sva.failures != 0)
    begin
      $display("a bound assertion on the stream or strobe protocol failed");
      abort_run();
    end
  end

  initial
  begin
    aclk = 1'b0;
    aresetn = 1'b0;
    bclk = 1'b0;
    lrclk = 1'b0;
    adc_sdata = 1'b0;
    s_tdata = '0;
    s_tvalid = 1'b0;
    m_tready = 1'b0;
    hold_ready = 1'b0;
    codec_lfsr = SEED;
    ready_lfsr = SEED;
    prev_right = '0;
    dac_left = '0;
    dac_right = '0;
    frames_sent = 0;
    tready_count = 0;
    repeat (10) @(negedge aclk);
    aresetn = 1'b1;

    repeat (20)
    begin
      @(negedge aclk);
      check_value("m_tvalid", m_tvalid, 32'h0);
      check_value("s_tready", s_tready, 32'h0);
      check_value("overrun", overrun, 32'h0);
      check_value("dac_sdata", dac_sdata, 32'h0);
    end

    send_preamble();
    send_frames(MAIN_FRAMES);
    check_value("s_tready pulse count", tready_count, MAIN_FRAMES);
    send_frames(1);
    wait_capture_drain();
    check_value("overrun", overrun, 32'h0);

    // two full groups complete while the output is stalled
    hold_ready = 1'b1;
    send_frames(2 * GROUP);
    check_value("m_tvalid", m_tvalid, 32'h1);
    check_value("overrun", overrun, 32'h1);
    check_value("m_tdata", m_tdata, capture_q[0]);
    capture_q.delete(1);
    hold_ready = 1'b0;
    wait_capture_drain();
    wait_tvalid_low();
    send_frames(2);
    check_value("overrun", overrun, 32'h1);
    check_value("m_tvalid", m_tvalid, 32'h0);
    check_value("s_tready pulse count", tready_count, frames_sent);

    if (dut.u_sva.failures == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: verification/i2s_codec_bridge_sva.sv
`timescale 1ns/1ps
`include "i2s_defines.svh"

module i2s_codec_bridge_sva
(
  input logic                        aclk,
  input logic                        aresetn,
  input logic                        lrclk,
  input logic [`I2S_FRAME_WIDTH-1:0] m_tdata,
  input logic                        m_tvalid,
  input logic                        m_tready,
  input logic                        s_tready,
  input logic                        overrun
);

  int failures;

  initial
  begin
    failures = 0;
  end

  // a stalled output word keeps both its valid and its data
  held_word_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata)))
  else
  begin
    failures++;
    $error("m_tvalid or m_tdata changed while m_tready was low");
  end

  // a playback request comes one decoder latency after an lrclk fall on the pin
  // and lasts a single cycle
  single_request: assert property (@(posedge aclk) disable iff (!aresetn)
    s_tready |-> ($past(lrclk, 4) && !$past(lrclk, 3)) ##1 !s_tready)
  else
  begin
    failures++;
    $error("s_tready did not follow an lrclk fall or was high for two cycles in a row");
  end

  overrun_sticky: assert property (@(posedge aclk) disable iff (!aresetn)
    overrun |=> overrun)
  else
  begin
    failures++;
    $error("overrun fell while aresetn was high");
  end

endmodule

bind i2s_codec_bridge i2s_codec_bridge_sva u_sva (
  .aclk     (aclk),
  .aresetn  (aresetn),
  .lrclk    (lrclk),
  .m_tdata  (m_tdata),
  .m_tvalid (m_tvalid),
  .m_tready (m_tready),
  .s_tready (s_tready),
  .overrun  (overrun)
);

// File: rtl/i2s_codec_bridge.sv
`timescale 1ns/1ps
`include "i2s_defines.svh"

module i2s_codec_bridge
(
  input  logic                        aclk,
  input  logic                        aresetn,
  input  logic                        bclk,
  input  logic                        lrclk,
  input  logic                        adc_sdata,
  output logic                        dac_sdata,
  input  logic [`I2S_FRAME_WIDTH-1:0] s_tdata,
  input  logic                        s_tvalid,
  output logic                        s_tready,
  output logic [`I2S_FRAME_WIDTH-1:0] m_tdata,
  output logic                        m_tvalid,
  input  logic                        m_tready,
  output logic                        overrun
);

  i2s_edge_if edges ();

  i2s_pkg::stereo_frame_t frame;
  logic                   frame_valid;

  // --------------------------------------------------
  // pin sync and edge strobes
  // --------------------------------------------------
  i2s_pin_decoder u_decoder (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .bclk      (bclk),
    .lrclk     (lrclk),
    .adc_sdata (adc_sdata),
    .edges     (edges)
  );

  // --------------------------------------------------
  // capture path
  // --------------------------------------------------
  i2s_adc_deserializer u_adc (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .edges       (edges),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  frame_decimator u_decim (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .frame       (frame),
    .frame_valid (frame_valid),
    .m_tdata     (m_tdata),
    .m_tvalid    (m_tvalid),
    .m_tready    (m_tready),
    .overrun     (overrun)
  );

  // playback path
  i2s_dac_serializer u_dac (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .edges     (edges),
    .s_tdata   (s_tdata),
    .s_tvalid  (s_tvalid),
    .s_tready  (s_tready),
    .dac_sdata (dac_sdata)
  );

endmodule

// File: rtl/frame_decimator.sv
`timescale 1ns/1ps
`include "i2s_defines.svh"

module frame_decimator
(
  input  logic                        aclk,
  input  logic                        aresetn,
  input  i2s_pkg::stereo_frame_t      frame,
  input  logic                        frame_valid,
  output logic [`I2S_FRAME_WIDTH-1:0] m_tdata,
  output logic                        m_tvalid,
  input  logic                        m_tready,
  output logic                        overrun
);

  localparam int W = `I2S_SAMPLE_WIDTH;
  localparam int ACC_W = W + `I2S_DECIM_LOG2;

  logic signed [ACC_W-1:0]    acc_left;
  logic signed [ACC_W-1:0]    acc_right;
  logic signed [ACC_W-1:0]    sum_left;
  logic signed [ACC_W-1:0]    sum_right;
  logic signed [ACC_W-1:0]    avg_left;
  logic signed [ACC_W-1:0]    avg_right;
  logic [`I2S_DECIM_LOG2-1:0] frame_cnt;
  logic                       group_done;
  logic                       out_held;
  i2s_pkg::stereo_frame_t     avg_frame;

  assign sum_left = acc_left + ACC_W'(frame.left);
  assign sum_right = acc_right + ACC_W'(frame.right);

  // arithmetic shift floors toward minus infinity, the sum never overflows
  assign avg_left = sum_left >>> `I2S_DECIM_LOG2;
  assign avg_right = sum_right >>> `I2S_DECIM_LOG2;
  assign avg_frame.left = avg_left[W-1:0];
  assign avg_frame.right = avg_right[W-1:0];

  assign group_done = frame_valid && (frame_cnt == '1);
  assign out_held = m_tvalid && !m_tready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      acc_left <= '0;
      acc_right <= '0;
      frame_cnt <= '0;
      m_tvalid <= 1'b0;
      overrun <= 1'b0;
    end
    else
    begin
      if (m_tvalid && m_tready)
      begin
        m_tvalid <= 1'b0;
      end

      if (frame_valid)
      begin
        frame_cnt <= frame_cnt + 1'b1;
        if (group_done)
        begin
          acc_left <= '0;
          acc_right <= '0;
          // the held word stays put and the new average is dropped
          if (out_held)
          begin
            overrun <= 1'b1;
          end
          else
          begin
            m_tvalid <= 1'b1;
          end
        end
        else
        begin
          acc_left <= sum_left;
          acc_right <= sum_right;
        end
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (group_done && !out_held)
    begin
      m_tdata <= avg_frame;
    end
  end

endmodule

// File: rtl/i2s_dac_serializer.sv
`timescale 1ns/1ps
`include "i2s_defines.svh"

module i2s_dac_serializer
(
  input  logic                        aclk,
  input  logic                        aresetn,
  i2s_edge_if.dac_sink                edges,
  input  logic [`I2S_FRAME_WIDTH-1:0] s_tdata,
  input  logic                        s_tvalid,
  output logic                        s_tready,
  output logic                        dac_sdata
);

  localparam int W = `I2S_SAMPLE_WIDTH;

  i2s_pkg::stereo_frame_t play_frame;
  logic [W-1:0]           shreg;
  logic                   load_pending;

  // a new frame is requested once per word clock, at the start of the left word
  assign s_tready = edges.lrclk_fall;
  assign dac_sdata = shreg[W-1];

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      play_frame <= '0;
      shreg <= '0;
      load_pending <= 1'b0;
    end
    else
    begin
      // no frame offered means this period plays silence
      if (edges.lrclk_fall)
      begin
        play_frame <= s_tvalid ? s_tdata : '0;
      end

      // a bclk fall together with the lrclk edge still sends the previous LSB
      if (edges.bclk_fall)
      begin
        if (load_pending)
        begin
          shreg <= edges.lrclk_level ? play_frame.right : play_frame.left;
          load_pending <= 1'b0;
        end
        else
        begin
          shreg <= {shreg[W-2:0], 1'b0};
        end
      end

      if (edges.lrclk_rise || edges.lrclk_fall)
      begin
        load_pending <= 1'b1;
      end
    end
  end

endmodule

// File: rtl/i2s_adc_deserializer.sv
`timescale 1ns/1ps
`include "i2s_defines.svh"

module i2s_adc_deserializer
(
  input  logic                   aclk,
  input  logic                   aresetn,
  i2s_edge_if.adc_sink           edges,
  output i2s_pkg::stereo_frame_t frame,
  output logic                   frame_valid
);

  localparam int W = `I2S_SAMPLE_WIDTH;
  localparam int CNT_W = $clog2(W + 1);

  logic [W-1:0]     word;
  logic [W-1:0]     word_next;
  logic [CNT_W-1:0] bit_cnt;
  logic             word_full;
  logic             commit_pending;
  logic             commit;
  logic             frame_load;
  i2s_pkg::sample_t left_q;
  logic             left_seen;

  // the one-bit I2S delay puts the LSB of the ending word on the first bclk
  // rise after the lrclk edge, so the word is finished on that rise
  assign commit = edges.bclk_rise & commit_pending;
  assign word_next = (bit_cnt < CNT_W'(W)) ? {word[W-2:0], edges.sdata} : word;
  assign word_full = (bit_cnt == CNT_W'(W - 1));
  assign frame_load = commit & ~edges.lrclk_level & left_seen & word_full;

  // --------------------------------------------------
  // bit counting and word pairing
  // --------------------------------------------------
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      bit_cnt <= CNT_W'(W);
      commit_pending <= 1'b0;
      left_seen <= 1'b0;
      frame_valid <= 1'b0;
    end
    else
    begin
      frame_valid <= 1'b0;
      if (commit)
      begin
        bit_cnt <= '0;
        commit_pending <= 1'b0;
        if (edges.lrclk_level)
        begin
          left_seen <= word_full;
        end
        else
        begin
          frame_valid <= left_seen & word_full;
          left_seen <= 1'b0;
        end
      end
      else if (edges.bclk_rise && (bit_cnt < CNT_W'(W)))
      begin
        bit_cnt <= bit_cnt + 1'b1;
      end

      if (edges.lrclk_rise || edges.lrclk_fall)
      begin
        commit_pending <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // shift register and sample holding
  // --------------------------------------------------
  always_ff @(posedge aclk)
  begin
    if (edges.bclk_rise)
    begin
      word <= word_next;
    end
    if (commit && edges.lrclk_level)
    begin
      left_q <= word_next;
    end
    if (frame_load)
    begin
      frame.left <= left_q;
      frame.right <= word_next;
    end
  end

endmodule

// File: rtl/i2s_pin_decoder.sv
`timescale 1ns/1ps

module i2s_pin_decoder
(
  input  logic       aclk,
  input  logic       aresetn,
  input  logic       bclk,
  input  logic       lrclk,
  input  logic       adc_sdata,
  i2s_edge_if.source edges
);

  // bits 0 and 1 are the synchronizer, bit 2 is the copy used for edge compare
  logic [2:0] bclk_sync;
  logic [2:0] lrclk_sync;
  logic [1:0] data_sync;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      bclk_sync <= '0;
      lrclk_sync <= '0;
      data_sync <= '0;
      edges.bclk_rise <= 1'b0;
      edges.bclk_fall <= 1'b0;
      edges.lrclk_rise <= 1'b0;
      edges.lrclk_fall <= 1'b0;
      edges.lrclk_level <= 1'b0;
      edges.sdata <= 1'b0;
    end
    else
    begin
      bclk_sync <= {bclk_sync[1:0], bclk};
      lrclk_sync <= {lrclk_sync[1:0], lrclk};
      data_sync <= {data_sync[0], adc_sdata};

      // strobes are registered, so a pin change shows up three cycles later
      edges.bclk_rise <= bclk_sync[1] & ~bclk_sync[2];
      edges.bclk_fall <= ~bclk_sync[1] & bclk_sync[2];
      edges.lrclk_rise <= lrclk_sync[1] & ~lrclk_sync[2];
      edges.lrclk_fall <= ~lrclk_sync[1] & lrclk_sync[2];

      // same depth as the strobes so level and data match each event
      edges.lrclk_level <= lrclk_sync[1];
      edges.sdata <= data_sync[1];
    end
  end

endmodule

// File: rtl/i2s_edge_if.sv
`timescale 1ns/1ps

interface i2s_edge_if;

  // one-cycle strobes from the synchronized codec clocks
  logic bclk_rise;
  logic bclk_fall;
  logic lrclk_rise;
  logic lrclk_fall;

  // levels delayed to line up with the strobes
  logic lrclk_level;
  logic sdata;

  modport source (
    output bclk_rise,
    output bclk_fall,
    output lrclk_rise,
    output lrclk_fall,
    output lrclk_level,
    output sdata
  );

  modport adc_sink (
    input bclk_rise,
    input bclk_fall,
    input lrclk_rise,
    input lrclk_fall,
    input lrclk_level,
    input sdata
  );

  modport dac_sink (
    input bclk_fall,
    input lrclk_rise,
    input lrclk_fall,
    input lrclk_level
  );

endinterface

// File: rtl/i2s_pkg.sv
package i2s_pkg;

  `include "i2s_defines.svh"

  // one channel word as carried on the serial line, two's complement
  typedef logic signed [`I2S_SAMPLE_WIDTH-1:0] sample_t;

  // left sits in the upper half so the struct lines up with the stream words
  typedef struct packed {
    sample_t left;
    sample_t right;
  } stereo_frame_t;

endpackage

// File: rtl/i2s_defines.svh
`ifndef I2S_DEFINES_SVH
`define I2S_DEFINES_SVH

// --------------------------------------------------
// I2S word and frame geometry
// --------------------------------------------------

// bits per channel word on the serial line
`define I2S_SAMPLE_WIDTH 16

// one stereo frame packs left and right words
`define I2S_FRAME_WIDTH 32

// frames averaged per output word, as a power of two
`define I2S_DECIM_LOG2 2

`endif
